// ==== hw/exu_consts.svh ====
////////////////////////////////////////////////////////////
// Execute-stage ALU constants
// Widths, decode group codes and link steps shared by the
// ALU datapath and its dispatch logic
////////////////////////////////////////////////////////////
`ifndef EXU_CONSTS_SVH
`define EXU_CONSTS_SVH

`define EXU_XLEN         32
`define EXU_PC_SIZE      32
`define EXU_RFIDX_WIDTH  5
`define EXU_SHAMT_WIDTH  5

// Decode word and its group field
`define EXU_INFO_WIDTH   20
`define EXU_GRP_WIDTH    2
`define EXU_GRP_ALU      2'd0
`define EXU_GRP_BJP      2'd1

// Link address step per instruction size
`define EXU_RV32_LEN     4
`define EXU_RV16_LEN     2

`endif

// ==== hw/exu_info_pkg.sv ====
////////////////////////////////////////////////////////////
// Decode information types
// One decode word, read either as the regular ALU view or
// as the branch/jump view depending on its group field
////////////////////////////////////////////////////////////
`include "exu_consts.svh"

package exu_info_pkg;

  // Regular ALU view, op bits are one-hot
  typedef struct packed {
    logic [`EXU_GRP_WIDTH-1:0] grp;
    logic                      rv32;
    logic                      op_add;
    logic                      op_sub;
    logic                      op_xor;
    logic                      op_sll;
    logic                      op_srl;
    logic                      op_sra;
    logic                      op_or;
    logic                      op_and;
    logic                      op_slt;
    logic                      op_sltu;
    logic                      op_lui;
    logic                      op2imm;  // Immediate as op2
    logic                      op1pc;   // PC as op1 (auipc)
    logic                      ecal;
    logic                      ebrk;
    logic                      wfi;
    logic [`EXU_INFO_WIDTH-20:0] pad;
  } exu_alu_info_t;

  // Branch/jump view, bgt and bgtu are really greater-or-equal
  typedef struct packed {
    logic [`EXU_GRP_WIDTH-1:0] grp;
    logic                      rv32;
    logic                      jump;
    logic                      bprdt;   // Predicted taken
    logic                      beq;
    logic                      bne;
    logic                      blt;
    logic                      bgt;
    logic                      bltu;
    logic                      bgtu;
    logic                      mret;
    logic                      fencei;
    logic [`EXU_INFO_WIDTH-14:0] pad;
  } exu_bjp_info_t;

  typedef union packed {
    exu_alu_info_t alu;
    exu_bjp_info_t bjp;
  } exu_info_u;

endpackage

// ==== hw/exu_alu_rglr.sv ====
////////////////////////////////////////////////////////////
// Regular ALU unit
// Turns ALU decode info into datapath requests and returns
// the datapath result along with its commit flags
////////////////////////////////////////////////////////////
`include "exu_consts.svh"

module exu_alu_rglr import exu_info_pkg::*; (
  input  logic                   clk,
  input  logic                   i_rst,
  input  logic [`EXU_XLEN-1:0]   i_rs1,
  input  logic [`EXU_XLEN-1:0]   i_rs2,
  input  logic [`EXU_XLEN-1:0]   i_imm,
  input  logic [`EXU_PC_SIZE-1:0] i_pc,
  input  exu_info_u              i_info,
  input  logic [`EXU_XLEN-1:0]   i_dpath_res,
  output logic [`EXU_XLEN-1:0]   o_wbck_wdat,
  output logic                   o_cmt_ecall,
  output logic                   o_cmt_ebreak,
  output logic                   o_cmt_wfi,
  output logic [`EXU_XLEN-1:0]   o_req_op1,
  output logic [`EXU_XLEN-1:0]   o_req_op2,
  output logic                   o_req_add,
  output logic                   o_req_sub,
  output logic                   o_req_xor,
  output logic                   o_req_sll,
  output logic                   o_req_srl,
  output logic                   o_req_sra,
  output logic                   o_req_or,
  output logic                   o_req_and,
  output logic                   o_req_slt,
  output logic                   o_req_sltu,
  output logic                   o_req_lui
);

  exu_alu_info_t info;

  assign info = i_info.alu;

  assign o_req_op1  = info.op1pc  ? i_pc  : i_rs1;  // auipc
  assign o_req_op2  = info.op2imm ? i_imm : i_rs2;
  assign o_req_add  = info.op_add;
  assign o_req_sub  = info.op_sub;
  assign o_req_xor  = info.op_xor;
  assign o_req_sll  = info.op_sll;
  assign o_req_srl  = info.op_srl;
  assign o_req_sra  = info.op_sra;
  assign o_req_or   = info.op_or;
  assign o_req_and  = info.op_and;
  assign o_req_slt  = info.op_slt;
  assign o_req_sltu = info.op_sltu;
  assign o_req_lui  = info.op_lui;

  assign o_wbck_wdat  = i_dpath_res;
  assign o_cmt_ecall  = info.ecal;
  assign o_cmt_ebreak = info.ebrk;
  assign o_cmt_wfi    = info.wfi;

  // Decoder must never hand over two ops at once
  a_op_onehot: assert property (@(posedge clk) disable iff (i_rst)
    (info.grp == `EXU_GRP_ALU) |-> $onehot0({info.op_add, info.op_sub, info.op_xor,
      info.op_sll, info.op_srl, info.op_sra, info.op_or, info.op_and,
      info.op_slt, info.op_sltu, info.op_lui}));

endmodule

// ==== hw/exu_alu_bjp.sv ====
////////////////////////////////////////////////////////////
// Branch and jump unit
// Requests compares or the link-address add from the shared
// datapath and resolves the branch outcome
////////////////////////////////////////////////////////////
`include "exu_consts.svh"

module exu_alu_bjp import exu_info_pkg::*; (
  input  logic [`EXU_XLEN-1:0]   i_rs1,
  input  logic [`EXU_XLEN-1:0]   i_rs2,
  input  logic [`EXU_PC_SIZE-1:0] i_pc,
  input  exu_info_u              i_info,
  input  logic [`EXU_XLEN-1:0]   i_add_res,
  input  logic                   i_cmp_res,
  output logic [`EXU_XLEN-1:0]   o_wbck_wdat,
  output logic                   o_cmt_bjp,
  output logic                   o_cmt_mret,
  output logic                   o_cmt_fencei,
  output logic                   o_cmt_prdt,
  output logic                   o_cmt_rslv,
  output logic [`EXU_XLEN-1:0]   o_req_op1,
  output logic [`EXU_XLEN-1:0]   o_req_op2,
  output logic                   o_req_cmp_eq,
  output logic                   o_req_cmp_ne,
  output logic                   o_req_cmp_lt,
  output logic                   o_req_cmp_gt,
  output logic                   o_req_cmp_ltu,
  output logic                   o_req_cmp_gtu,
  output logic                   o_req_add
);

  exu_bjp_info_t        info;
  logic                 bxx;
  logic [`EXU_XLEN-1:0] link_len;

  assign info = i_info.bjp;
  assign bxx  = info.beq | info.bne | info.blt | info.bgt | info.bltu | info.bgtu;

  assign link_len = info.rv32 ? `EXU_XLEN'(`EXU_RV32_LEN) : `EXU_XLEN'(`EXU_RV16_LEN);

  // Jump adds pc + len for the link, branch compares rs1/rs2
  assign o_req_op1     = info.jump ? i_pc     : i_rs1;
  assign o_req_op2     = info.jump ? link_len : i_rs2;
  assign o_req_add     = info.jump;
  assign o_req_cmp_eq  = info.beq;
  assign o_req_cmp_ne  = info.bne;
  assign o_req_cmp_lt  = info.blt;
  assign o_req_cmp_gt  = info.bgt;
  assign o_req_cmp_ltu = info.bltu;
  assign o_req_cmp_gtu = info.bgtu;

  assign o_wbck_wdat  = i_add_res;  // Link address
  assign o_cmt_bjp    = info.jump | bxx;
  assign o_cmt_mret   = info.mret;
  assign o_cmt_fencei = info.fencei;
  assign o_cmt_prdt   = info.bprdt;
  assign o_cmt_rslv   = info.jump | i_cmp_res;  // Jumps always taken

endmodule

// ==== hw/exu_alu_dpath.sv ====
////////////////////////////////////////////////////////////
// Shared ALU datapath
// One adder, shifter, logic block and comparator, driven by
// whichever unit raises its request
////////////////////////////////////////////////////////////
`include "exu_consts.svh"

module exu_alu_dpath (
  input  logic                 clk,
  input  logic                 i_rst,
  input  logic                 i_alu_req,
  input  logic [`EXU_XLEN-1:0] i_alu_op1,
  input  logic [`EXU_XLEN-1:0] i_alu_op2,
  input  logic                 i_alu_add,
  input  logic                 i_alu_sub,
  input  logic                 i_alu_xor,
  input  logic                 i_alu_sll,
  input  logic                 i_alu_srl,
  input  logic                 i_alu_sra,
  input  logic                 i_alu_or,
  input  logic                 i_alu_and,
  input  logic                 i_alu_slt,
  input  logic                 i_alu_sltu,
  input  logic                 i_alu_lui,
  input  logic                 i_bjp_req,
  input  logic [`EXU_XLEN-1:0] i_bjp_op1,
  input  logic [`EXU_XLEN-1:0] i_bjp_op2,
  input  logic                 i_bjp_cmp_eq,
  input  logic                 i_bjp_cmp_ne,
  input  logic                 i_bjp_cmp_lt,
  input  logic                 i_bjp_cmp_gt,
  input  logic                 i_bjp_cmp_ltu,
  input  logic                 i_bjp_cmp_gtu,
  input  logic                 i_bjp_add,
  output logic [`EXU_XLEN-1:0] o_alu_res,
  output logic [`EXU_XLEN-1:0] o_bjp_add_res,
  output logic                 o_bjp_cmp_res
);

  logic [`EXU_XLEN-1:0]        op1;
  logic [`EXU_XLEN-1:0]        op2;
  logic [`EXU_SHAMT_WIDTH-1:0] shamt;
  logic [`EXU_XLEN:0]          add_in1;
  logic [`EXU_XLEN:0]          add_in2;
  logic [`EXU_XLEN:0]          add_res;
  logic [`EXU_XLEN-1:0]        xor_res;
  logic [`EXU_XLEN-1:0]        sra_res;
  logic                        op_add;
  logic                        op_sub;
  logic                        op_ge;
  logic                        op_lt;
  logic                        need_sub;
  logic                        op_signed;
  logic                        lt;
  logic                        eq;

  ////////////////////////////////////////////////////////////
  // Operand and strobe select, zero when nobody asks
  assign op1 = ({`EXU_XLEN{i_alu_req}} & i_alu_op1) | ({`EXU_XLEN{i_bjp_req}} & i_bjp_op1);
  assign op2 = ({`EXU_XLEN{i_alu_req}} & i_alu_op2) | ({`EXU_XLEN{i_bjp_req}} & i_bjp_op2);

  assign op_add = (i_alu_req & i_alu_add) | (i_bjp_req & i_bjp_add);
  assign op_sub = i_alu_req & i_alu_sub;
  assign op_lt  = i_bjp_req & (i_bjp_cmp_lt | i_bjp_cmp_ltu);
  assign op_ge  = i_bjp_req & (i_bjp_cmp_gt | i_bjp_cmp_gtu);

  ////////////////////////////////////////////////////////////
  // Adder, compares go through a 33-bit subtract
  assign need_sub  = op_sub | op_lt | op_ge | (i_alu_req & (i_alu_slt | i_alu_sltu));
  assign op_signed = (i_alu_req & i_alu_slt) | (i_bjp_req & (i_bjp_cmp_lt | i_bjp_cmp_gt));

  assign add_in1 = {op_signed & op1[`EXU_XLEN-1], op1};  // Sign or zero extend
  assign add_in2 = {op_signed & op2[`EXU_XLEN-1], op2};
  assign add_res = need_sub ? (add_in1 + ~add_in2 + 1'b1) : (add_in1 + add_in2);

  assign lt      = add_res[`EXU_XLEN];
  assign xor_res = op1 ^ op2;
  assign eq      = ~(|xor_res);

  assign shamt   = op2[`EXU_SHAMT_WIDTH-1:0];
  assign sra_res = $unsigned($signed(op1) >>> shamt);

  ////////////////////////////////////////////////////////////
  // Results
  assign o_alu_res =
      ({`EXU_XLEN{op_add | op_sub}} & add_res[`EXU_XLEN-1:0])
    | ({`EXU_XLEN{i_alu_req & i_alu_xor}} & xor_res)
    | ({`EXU_XLEN{i_alu_req & i_alu_or}}  & (op1 | op2))
    | ({`EXU_XLEN{i_alu_req & i_alu_and}} & (op1 & op2))
    | ({`EXU_XLEN{i_alu_req & i_alu_sll}} & (op1 << shamt))
    | ({`EXU_XLEN{i_alu_req & i_alu_srl}} & (op1 >> shamt))
    | ({`EXU_XLEN{i_alu_req & i_alu_sra}} & sra_res)
    | ({`EXU_XLEN{i_alu_req & (i_alu_slt | i_alu_sltu)}} & {{(`EXU_XLEN-1){1'b0}}, lt})
    | ({`EXU_XLEN{i_alu_req & i_alu_lui}} & op2);

  assign o_bjp_add_res = add_res[`EXU_XLEN-1:0];
  assign o_bjp_cmp_res = (i_bjp_req & i_bjp_cmp_eq & eq)
                       | (i_bjp_req & i_bjp_cmp_ne & ~eq)
                       | (op_lt & lt)
                       | (op_ge & ~lt);  // gt strobes mean >=

  // Dispatch masking keeps the two requesters apart
  a_one_req: assert property (@(posedge clk) disable iff (i_rst) !(i_alu_req && i_bjp_req));

endmodule

// ==== hw/exu_alu.sv ====
////////////////////////////////////////////////////////////
// Execute-stage ALU top
// Dispatches by decode group to the regular ALU or branch
// unit, turns fetch faults into error results, and drives
// the commit and write-back handshakes
////////////////////////////////////////////////////////////
`include "exu_consts.svh"

module exu_alu import exu_info_pkg::*; (
  input  logic                       clk,
  input  logic                       i_rst,
  input  logic                       i_valid,
  output logic                       o_ready,
  input  logic [`EXU_XLEN-1:0]       i_rs1,
  input  logic [`EXU_XLEN-1:0]       i_rs2,
  input  logic [`EXU_XLEN-1:0]       i_imm,
  input  exu_info_u                  i_info,
  input  logic [`EXU_PC_SIZE-1:0]    i_pc,
  input  logic [`EXU_XLEN-1:0]       i_instr,
  input  logic                       i_pc_vld,
  input  logic [`EXU_RFIDX_WIDTH-1:0] i_rdidx,
  input  logic                       i_rdwen,
  input  logic                       i_ilegl,
  input  logic                       i_buserr,
  input  logic                       i_misalgn,
  input  logic                       i_cmt_ready,
  input  logic                       i_wbck_ready,
  output logic                       o_cmt_valid,
  output logic [`EXU_PC_SIZE-1:0]    o_cmt_pc,
  output logic [`EXU_XLEN-1:0]       o_cmt_instr,
  output logic [`EXU_XLEN-1:0]       o_cmt_imm,
  output logic                       o_cmt_pc_vld,
  output logic                       o_cmt_rv32,
  output logic                       o_cmt_bjp,
  output logic                       o_cmt_mret,
  output logic                       o_cmt_fencei,
  output logic                       o_cmt_ecall,
  output logic                       o_cmt_ebreak,
  output logic                       o_cmt_wfi,
  output logic                       o_cmt_bjp_prdt,
  output logic                       o_cmt_bjp_rslv,
  output logic                       o_cmt_ifu_misalgn,
  output logic                       o_cmt_ifu_buserr,
  output logic                       o_cmt_ifu_ilegl,
  output logic                       o_wbck_valid,
  output logic [`EXU_XLEN-1:0]       o_wbck_wdat,
  output logic [`EXU_RFIDX_WIDTH-1:0] o_wbck_rdidx
);

  logic ifu_excp;
  logic alu_op;
  logic bjp_op;
  logic err;
  logic need_wbck;
  logic res_ready;

  assign ifu_excp = i_ilegl | i_buserr | i_misalgn;  // Overrides the group
  assign alu_op   = ~ifu_excp & (i_info.alu.grp == `EXU_GRP_ALU);
  assign bjp_op   = ~ifu_excp & (i_info.alu.grp == `EXU_GRP_BJP);

  ////////////////////////////////////////////////////////////
  // Regular ALU
  exu_info_u            alu_info;
  logic [`EXU_XLEN-1:0] alu_wdat;
  logic [`EXU_XLEN-1:0] alu_op1;
  logic [`EXU_XLEN-1:0] alu_op2;
  logic [`EXU_XLEN-1:0] alu_res;
  logic alu_ecall;
  logic alu_ebreak;
  logic alu_wfi;
  logic alu_add;
  logic alu_sub;
  logic alu_xor;
  logic alu_sll;
  logic alu_srl;
  logic alu_sra;
  logic alu_or;
  logic alu_and;
  logic alu_slt;
  logic alu_sltu;
  logic alu_lui;

  assign alu_info = {`EXU_INFO_WIDTH{alu_op}} & i_info;

  exu_alu_rglr u_rglr (
    .clk (clk), .i_rst (i_rst),
    .i_rs1 ({`EXU_XLEN{alu_op}} & i_rs1),
    .i_rs2 ({`EXU_XLEN{alu_op}} & i_rs2),
    .i_imm ({`EXU_XLEN{alu_op}} & i_imm),
    .i_pc ({`EXU_PC_SIZE{alu_op}} & i_pc),
    .i_info (alu_info), .i_dpath_res (alu_res), .o_wbck_wdat (alu_wdat),
    .o_cmt_ecall (alu_ecall), .o_cmt_ebreak (alu_ebreak), .o_cmt_wfi (alu_wfi),
    .o_req_op1 (alu_op1), .o_req_op2 (alu_op2),
    .o_req_add (alu_add), .o_req_sub (alu_sub), .o_req_xor (alu_xor),
    .o_req_sll (alu_sll), .o_req_srl (alu_srl), .o_req_sra (alu_sra),
    .o_req_or (alu_or), .o_req_and (alu_and), .o_req_slt (alu_slt),
    .o_req_sltu (alu_sltu), .o_req_lui (alu_lui)
  );

  ////////////////////////////////////////////////////////////
  // Branch and jump
  exu_info_u            bjp_info;
  logic [`EXU_XLEN-1:0] bjp_wdat;
  logic [`EXU_XLEN-1:0] bjp_op1;
  logic [`EXU_XLEN-1:0] bjp_op2;
  logic [`EXU_XLEN-1:0] bjp_add_res;
  logic bjp_cmp_res;
  logic bjp_bjp;
  logic bjp_mret;
  logic bjp_fencei;
  logic bjp_prdt;
  logic bjp_rslv;
  logic bjp_eq;
  logic bjp_ne;
  logic bjp_lt;
  logic bjp_gt;
  logic bjp_ltu;
  logic bjp_gtu;
  logic bjp_add;

  assign bjp_info = {`EXU_INFO_WIDTH{bjp_op}} & i_info;

  exu_alu_bjp u_bjp (
    .i_rs1 ({`EXU_XLEN{bjp_op}} & i_rs1),
    .i_rs2 ({`EXU_XLEN{bjp_op}} & i_rs2),
    .i_pc ({`EXU_PC_SIZE{bjp_op}} & i_pc),
    .i_info (bjp_info), .i_add_res (bjp_add_res), .i_cmp_res (bjp_cmp_res),
    .o_wbck_wdat (bjp_wdat), .o_cmt_bjp (bjp_bjp), .o_cmt_mret (bjp_mret),
    .o_cmt_fencei (bjp_fencei), .o_cmt_prdt (bjp_prdt), .o_cmt_rslv (bjp_rslv),
    .o_req_op1 (bjp_op1), .o_req_op2 (bjp_op2),
    .o_req_cmp_eq (bjp_eq), .o_req_cmp_ne (bjp_ne), .o_req_cmp_lt (bjp_lt),
    .o_req_cmp_gt (bjp_gt), .o_req_cmp_ltu (bjp_ltu), .o_req_cmp_gtu (bjp_gtu),
    .o_req_add (bjp_add)
  );

  ////////////////////////////////////////////////////////////
  // Shared datapath, ALU only asks when it writes back
  exu_alu_dpath u_dpath (
    .clk (clk), .i_rst (i_rst),
    .i_alu_req (alu_op & i_rdwen), .i_alu_op1 (alu_op1), .i_alu_op2 (alu_op2),
    .i_alu_add (alu_add), .i_alu_sub (alu_sub), .i_alu_xor (alu_xor),
    .i_alu_sll (alu_sll), .i_alu_srl (alu_srl), .i_alu_sra (alu_sra),
    .i_alu_or (alu_or), .i_alu_and (alu_and), .i_alu_slt (alu_slt),
    .i_alu_sltu (alu_sltu), .i_alu_lui (alu_lui),
    .i_bjp_req (bjp_op), .i_bjp_op1 (bjp_op1), .i_bjp_op2 (bjp_op2),
    .i_bjp_cmp_eq (bjp_eq), .i_bjp_cmp_ne (bjp_ne), .i_bjp_cmp_lt (bjp_lt),
    .i_bjp_cmp_gt (bjp_gt), .i_bjp_cmp_ltu (bjp_ltu), .i_bjp_cmp_gtu (bjp_gtu),
    .i_bjp_add (bjp_add),
    .o_alu_res (alu_res), .o_bjp_add_res (bjp_add_res), .o_bjp_cmp_res (bjp_cmp_res)
  );

  ////////////////////////////////////////////////////////////
  // Result arbitration and handshake
  assign err       = ifu_excp;  // Fetch fault gives zero data
  assign need_wbck = i_rdwen & ~err;
  assign res_ready = i_cmt_ready & (~need_wbck | i_wbck_ready);
  assign o_ready   = res_ready;

  // Commit and write-back complete together or not at all
  assign o_cmt_valid  = i_valid & (~need_wbck | i_wbck_ready);
  assign o_wbck_valid = need_wbck & i_valid & i_cmt_ready;
  assign o_wbck_wdat  = ({`EXU_XLEN{alu_op}} & alu_wdat) | ({`EXU_XLEN{bjp_op}} & bjp_wdat);
  assign o_wbck_rdidx = i_rdidx;

  assign o_cmt_pc     = i_pc;
  assign o_cmt_instr  = i_instr;
  assign o_cmt_imm    = i_imm;
  assign o_cmt_pc_vld = i_pc_vld;
  assign o_cmt_rv32   = i_info.alu.rv32;  // Same bit in both views

  assign o_cmt_bjp      = bjp_op & bjp_bjp;
  assign o_cmt_mret     = bjp_op & bjp_mret;
  assign o_cmt_fencei   = bjp_op & bjp_fencei;
  assign o_cmt_bjp_prdt = bjp_op & bjp_prdt;
  assign o_cmt_bjp_rslv = bjp_op & bjp_rslv;
  assign o_cmt_ecall    = alu_op & alu_ecall;
  assign o_cmt_ebreak   = alu_op & alu_ebreak;
  assign o_cmt_wfi      = alu_op & alu_wfi;

  assign o_cmt_ifu_misalgn = i_misalgn;
  assign o_cmt_ifu_buserr  = i_buserr;
  assign o_cmt_ifu_ilegl   = i_ilegl;

  // Decode only ever issues the two supported groups
  a_grp_known: assert property (@(posedge clk) disable iff (i_rst)
    (i_valid && !ifu_excp) |-> (alu_op || bjp_op));

endmodule

// ==== dv/exu_alu_tb.sv ====
////////////////////////////////////////////////////////////
// Execute-stage ALU testbench
// Random instructions through the ALU, branch and fetch
// fault paths, checked against a reference model
////////////////////////////////////////////////////////////
`include "exu_consts.svh"

module exu_alu_tb import exu_info_pkg::*; ();

  localparam int NUM_TESTS      = 300;
  localparam int TIMEOUT_CYCLES = NUM_TESTS * 8 + 50;
  localparam logic [31:0] SEED  = 32'h498b;

  typedef struct packed {
    logic [`EXU_XLEN-1:0] wdat;
    logic wdat_vld;
    logic need_wbck;
    logic bjp;
    logic mret;
    logic fencei;
    logic ecall;
    logic ebreak;
    logic wfi;
    logic prdt;
    logic rslv;
  } exp_res_t;

  logic clk, i_rst, i_valid, o_ready;
  logic [`EXU_XLEN-1:0] i_rs1, i_rs2, i_imm, i_instr;
  logic [`EXU_PC_SIZE-1:0] i_pc;
  exu_info_u i_info;
  logic i_pc_vld, i_rdwen, i_ilegl, i_buserr, i_misalgn, i_cmt_ready, i_wbck_ready;
  logic [`EXU_RFIDX_WIDTH-1:0] i_rdidx, o_wbck_rdidx;
  logic o_cmt_valid, o_cmt_pc_vld, o_cmt_rv32, o_cmt_bjp, o_cmt_mret, o_cmt_fencei;
  logic o_cmt_ecall, o_cmt_ebreak, o_cmt_wfi, o_cmt_bjp_prdt, o_cmt_bjp_rslv;
  logic o_cmt_ifu_misalgn, o_cmt_ifu_buserr, o_cmt_ifu_ilegl, o_wbck_valid;
  logic [`EXU_PC_SIZE-1:0] o_cmt_pc;
  logic [`EXU_XLEN-1:0] o_cmt_instr, o_cmt_imm, o_wbck_wdat;

  string cur_name;
  int tests_done, tests_failed, test_errs, err_count, cycles;
  string alu_names[14] = '{"add", "sub", "xor", "sll", "srl", "sra", "or", "and",
                           "slt", "sltu", "lui", "ecall", "ebreak", "wfi"};
  string bjp_names[9]  = '{"jump", "beq", "bne", "blt", "bge", "bltu", "bgeu",
                           "mret", "fencei"};

  exu_alu dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // Reference model
  function automatic exp_res_t ref_result(input exu_info_u info,
      input logic [`EXU_XLEN-1:0] rs1, input logic [`EXU_XLEN-1:0] rs2,
      input logic [`EXU_XLEN-1:0] imm, input logic [`EXU_PC_SIZE-1:0] pc,
      input logic rdwen, input logic fault);
    exp_res_t r;
    logic [`EXU_XLEN-1:0] a;
    logic [`EXU_XLEN-1:0] b;
    logic [4:0] sh;
    r = '0;
    a = info.alu.op1pc ? pc : rs1;
    b = info.alu.op2imm ? imm : rs2;
    sh = b[4:0];
    if (fault) begin
      r.wdat_vld = 1'b1;  // Zero data and no write-back
    end else if (info.alu.grp == `EXU_GRP_ALU) begin
      r.need_wbck = rdwen;
      r.wdat_vld  = rdwen;
      if (rdwen && info.alu.op_add) r.wdat = a + b;
      if (rdwen && info.alu.op_sub) r.wdat = a - b;
      if (rdwen && info.alu.op_xor) r.wdat = a ^ b;
      if (rdwen && info.alu.op_sll) r.wdat = a << sh;
      if (rdwen && info.alu.op_srl) r.wdat = a >> sh;
      if (rdwen && info.alu.op_sra) r.wdat = $unsigned($signed(a) >>> sh);
      if (rdwen && info.alu.op_or) r.wdat = a | b;
      if (rdwen && info.alu.op_and) r.wdat = a & b;
      if (rdwen && info.alu.op_slt) r.wdat = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      if (rdwen && info.alu.op_sltu) r.wdat = (a < b) ? 32'd1 : 32'd0;
      if (rdwen && info.alu.op_lui) r.wdat = b;
      r.ecall  = info.alu.ecal;
      r.ebreak = info.alu.ebrk;
      r.wfi    = info.alu.wfi;
    end else begin
      r.need_wbck = rdwen;
      r.wdat_vld  = rdwen & info.bjp.jump;
      r.wdat      = pc + (info.bjp.rv32 ? 32'd4 : 32'd2);  // Link address
      r.bjp = info.bjp.jump | info.bjp.beq | info.bjp.bne | info.bjp.blt
            | info.bjp.bgt | info.bjp.bltu | info.bjp.bgtu;
      r.mret   = info.bjp.mret;
      r.fencei = info.bjp.fencei;
      r.prdt   = info.bjp.bprdt;
      r.rslv = info.bjp.jump
             | (info.bjp.beq & (rs1 == rs2))
             | (info.bjp.bne & (rs1 != rs2))
             | (info.bjp.blt & ($signed(rs1) < $signed(rs2)))
             | (info.bjp.bgt & ($signed(rs1) >= $signed(rs2)))  // bgt means >=
             | (info.bjp.bltu & (rs1 < rs2))
             | (info.bjp.bgtu & (rs1 >= rs2));
    end
    return r;
  endfunction

  ////////////////////////////////////////////////////////////
  // Stimulus
  task automatic drive_readies();
    logic [31:0] rnd;
    rnd = $urandom;
    i_cmt_ready  <= (rnd[1:0] != 2'd0);  // High 3 of 4 cycles
    i_wbck_ready <= (rnd[3:2] != 2'd0);
  endtask

  task automatic drive_random_instr();
    exu_info_u info;
    logic [31:0] rnd;
    logic [31:0] pad_rnd;
    logic [`EXU_XLEN-1:0] rs1;
    int unsigned kind;
    logic fault;
    string nm;
    info  = '0;
    rnd   = $urandom;
    rs1   = $urandom;
    fault = (rnd[2:0] == 3'd0);
    info.alu.grp  = rnd[3] ? `EXU_GRP_BJP : `EXU_GRP_ALU;
    info.alu.rv32 = rnd[4];
    if (info.alu.grp == `EXU_GRP_ALU) begin
      kind = $urandom % 14;
      nm = alu_names[kind];
      case (kind)
        0: info.alu.op_add = 1'b1;
        1: info.alu.op_sub = 1'b1;
        2: info.alu.op_xor = 1'b1;
        3: info.alu.op_sll = 1'b1;
        4: info.alu.op_srl = 1'b1;
        5: info.alu.op_sra = 1'b1;
        6: info.alu.op_or = 1'b1;
        7: info.alu.op_and = 1'b1;
        8: info.alu.op_slt = 1'b1;
        9: info.alu.op_sltu = 1'b1;
        10: info.alu.op_lui = 1'b1;
        11: info.alu.ecal = 1'b1;
        12: info.alu.ebrk = 1'b1;
        default: info.alu.wfi = 1'b1;
      endcase
      info.alu.op2imm = rnd[5];
      info.alu.op1pc  = rnd[6];
      i_rdwen <= rnd[7];
    end else begin
      kind = $urandom % 9;
      nm = bjp_names[kind];
      case (kind)
        0: info.bjp.jump = 1'b1;
        1: info.bjp.beq = 1'b1;
        2: info.bjp.bne = 1'b1;
        3: info.bjp.blt = 1'b1;
        4: info.bjp.bgt = 1'b1;
        5: info.bjp.bltu = 1'b1;
        6: info.bjp.bgtu = 1'b1;
        7: info.bjp.mret = 1'b1;
        default: info.bjp.fencei = 1'b1;
      endcase
      info.bjp.bprdt = rnd[5];
      pad_rnd = $urandom;
      info.bjp.pad = pad_rnd[`EXU_INFO_WIDTH-14:0];  // Spare bits overlap the ALU flags
      i_rdwen <= (kind == 0) & rnd[7];  // Only jumps write a link
    end
    i_valid   <= 1'b1;
    i_info    <= info;
    i_rs1     <= rs1;
    i_rs2     <= (rnd[9:8] == 2'd0) ? rs1 : $urandom;  // Equal operands now and then
    i_imm     <= $urandom;
    i_pc      <= {rnd[31:13], 12'h000, 1'b0} | {19'd0, rnd[12:10], 10'd0};
    i_instr   <= $urandom;
    i_pc_vld  <= rnd[11];
    i_rdidx   <= rnd[16:12];
    i_ilegl   <= fault & (rnd[18:17] == 2'd0);
    i_buserr  <= fault & (rnd[18:17] == 2'd1);
    i_misalgn <= fault & rnd[18];
    cur_name  <= fault ? {"fault_", nm} : nm;
  endtask

  ////////////////////////////////////////////////////////////
  // Checking
  task automatic check_word(string name, string field, logic [31:0] exp, logic [31:0] act);
    if (exp !== act) begin
      $display("FAILED %s %s: expected %0h actual %0h", name, field, exp, act);
      test_errs++;
      err_count++;
    end
  endtask

  task automatic check_bit(string name, string field, logic exp, logic act);
    if (exp !== act) begin
      $display("FAILED %s %s: expected %0b actual %0b", name, field, exp, act);
      test_errs++;
      err_count++;
    end
  endtask

  always @(posedge clk) begin : compare_blk
    exp_res_t e;
    logic fault;
    string name;
    if (!i_rst && !i_valid) begin
      if (o_cmt_valid || o_wbck_valid) begin
        $display("ERROR: commit or write-back valid high with no instruction offered");
        err_count++;
      end
    end else if (!i_rst) begin
      fault = i_ilegl | i_buserr | i_misalgn;
      e = ref_result(i_info, i_rs1, i_rs2, i_imm, i_pc, i_rdwen, fault);
      name = $sformatf("test %0d %s", tests_done, cur_name);
      check_bit(name, "ready", i_cmt_ready & (~e.need_wbck | i_wbck_ready), o_ready);
      check_bit(name, "cmt_valid", ~e.need_wbck | i_wbck_ready, o_cmt_valid);
      check_bit(name, "wbck_valid", e.need_wbck & i_cmt_ready, o_wbck_valid);
      if (o_ready) begin  // Accepting edge
        if (e.wdat_vld) check_word(name, "wdat", e.wdat, o_wbck_wdat);
        check_bit(name, "bjp", e.bjp, o_cmt_bjp);
        check_bit(name, "mret", e.mret, o_cmt_mret);
        check_bit(name, "fencei", e.fencei, o_cmt_fencei);
        check_bit(name, "ecall", e.ecall, o_cmt_ecall);
        check_bit(name, "ebreak", e.ebreak, o_cmt_ebreak);
        check_bit(name, "wfi", e.wfi, o_cmt_wfi);
        check_bit(name, "prdt", e.prdt, o_cmt_bjp_prdt);
        check_bit(name, "rslv", e.rslv, o_cmt_bjp_rslv);
        check_word(name, "pc", i_pc, o_cmt_pc);
        check_word(name, "instr", i_instr, o_cmt_instr);
        check_word(name, "imm", i_imm, o_cmt_imm);
        check_word(name, "rdidx", 32'(i_rdidx), 32'(o_wbck_rdidx));
        check_bit(name, "pc_vld", i_pc_vld, o_cmt_pc_vld);
        check_bit(name, "rv32", i_info.alu.rv32, o_cmt_rv32);
        check_bit(name, "ilegl", i_ilegl, o_cmt_ifu_ilegl);
        check_bit(name, "buserr", i_buserr, o_cmt_ifu_buserr);
        check_bit(name, "misalgn", i_misalgn, o_cmt_ifu_misalgn);
        $display("%s: %s", name, (test_errs == 0) ? "pass" : "mismatch");
        if (test_errs != 0) tests_failed++;
        test_errs = 0;
        tests_done++;
      end
    end
  end

  // Run limit
  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("ERROR: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST FAILED");
      $finish;
    end
  end

  initial begin : stim_blk
    logic accepted;
    void'($urandom(SEED));
    i_rst = 1'b1;
    i_valid = 1'b0;
    i_rs1 = '0;
    i_rs2 = '0;
    i_imm = '0;
    i_info = '0;
    i_pc = '0;
    i_instr = '0;
    i_pc_vld = 1'b0;
    i_rdidx = '0;
    i_rdwen = 1'b0;
    i_ilegl = 1'b0;
    i_buserr = 1'b0;
    i_misalgn = 1'b0;
    i_cmt_ready = 1'b0;
    i_wbck_ready = 1'b0;
    cur_name = "";
    repeat (2) @(posedge clk);
    i_rst <= 1'b0;
    @(posedge clk);
    for (int n = 0; n < NUM_TESTS; n++) begin
      drive_random_instr();
      drive_readies();
      accepted = 1'b0;
      while (!accepted) begin
        @(posedge clk);
        accepted = i_valid && o_ready;
        if (!accepted) drive_readies();  // Hold instruction under new back-pressure
      end
    end
    i_valid <= 1'b0;
    repeat (2) @(posedge clk);
    $display("tests: %0d run, %0d passed, %0d failed, %0d check errors",
             tests_done, tests_done - tests_failed, tests_failed, err_count);
    if (err_count == 0 && tests_done == NUM_TESTS) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
+incdir+hw
hw/exu_info_pkg.sv
hw/exu_alu_rglr.sv
hw/exu_alu_bjp.sv
hw/exu_alu_dpath.sv
hw/exu_alu.sv
dv/exu_alu_tb.sv

// ==== Makefile ====
SIM       := verilator
TOP       := exu_alu_tb
FILELIST  := filelist.f
SIM_FLAGS := --binary --timing --assert -j 0
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))
HEADERS   := $(wildcard hw/*.svh)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "TEST OK" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
